/* design/cnn_macros.svh */
`ifndef CNN_MACROS_SVH
`define CNN_MACROS_SVH

// Activation and weight widths
`define CNN_ACT_W       8
`define CNN_W_W         2

// Input frame geometry
`define CNN_IMG_W       10
`define CNN_IMG_H       10
`define CNN_KER         3

// Channel counts of the depthwise and pointwise stages
`define CNN_IN_CH       2
`define CNN_OUT_CH      4

// Requantization shifts after each stage
`define CNN_DW_SHIFT    2
`define CNN_PW_SHIFT    1

// Equals log2 of the 64 output positions of the 8x8 map
`define CNN_POOL_SHIFT  6

// Wide enough for both row and column positions
`define CNN_COL_W       4

`endif

/* design/cnn_pkg.sv */
`default_nettype none

`include "cnn_macros.svh"

package cnn_pkg;

    typedef logic [`CNN_ACT_W-1:0] act_t;
    typedef logic signed [`CNN_W_W-1:0] weight_t;

    typedef struct packed {
        act_t [`CNN_IN_CH-1:0] ch;
    } in_pixel_t;

    typedef struct packed {
        act_t [`CNN_OUT_CH-1:0] ch;
    } out_pixel_t;

    // Indexed as px[row][col], row 0 is the oldest line and col 0 the oldest column
    typedef struct packed {
        in_pixel_t [`CNN_KER-1:0][`CNN_KER-1:0] px;
    } window_t;

    // Depthwise taps as [channel][row][col]
    localparam weight_t DW_WEIGHTS [`CNN_IN_CH][`CNN_KER][`CNN_KER] = '{
        '{
            '{-2, -1,  0},
            '{ 1, -2, -1},
            '{ 0,  1, -2}
        },
        '{
            '{-1,  0,  1},
            '{-2, -1,  0},
            '{ 1, -2, -1}
        }
    };

    // Pointwise taps as [output channel][input channel]
    localparam weight_t PW_WEIGHTS [`CNN_OUT_CH][`CNN_IN_CH] = '{
        '{-2,  0},
        '{-1,  1},
        '{ 0, -2},
        '{ 1, -1}
    };

endpackage

`default_nettype wire

/* design/window_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cnn_macros.svh"

module window_buffer (
    input  wire logic                clk,
    input  wire logic                rstn,
    input  wire logic                valid,
    input  wire cnn_pkg::in_pixel_t  pixel,
    output logic                     win_valid,
    output cnn_pkg::window_t         window
);

    import cnn_pkg::*;

    logic [`CNN_COL_W-1:0] col_cnt;
    logic [`CNN_COL_W-1:0] row_cnt;
    logic                  col_last;
    logic                  row_last;
    logic                  win_done;

    // line1 holds the previous row, line2 the row before that
    in_pixel_t line1 [`CNN_IMG_W];
    in_pixel_t line2 [`CNN_IMG_W];

    // Incoming window column, top entry first
    in_pixel_t new_col [`CNN_KER];

    always_comb begin
        new_col[0] = line2[col_cnt];
        new_col[1] = line1[col_cnt];
        new_col[2] = pixel;
    end

    assign col_last = (col_cnt == `CNN_COL_W'(`CNN_IMG_W - 1));
    assign row_last = (row_cnt == `CNN_COL_W'(`CNN_IMG_H - 1));

    // A full 3x3 window exists once two rows and two columns lie behind the pixel
    assign win_done = (row_cnt >= `CNN_COL_W'(`CNN_KER - 1)) &&
                      (col_cnt >= `CNN_COL_W'(`CNN_KER - 1));

    always_ff @(posedge clk) begin
        if (valid) begin
            line2[col_cnt] <= line1[col_cnt];
            line1[col_cnt] <= pixel;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            col_cnt   <= '0;
            row_cnt   <= '0;
            win_valid <= 1'b0;
            window    <= '0;
        end else begin
            win_valid <= valid && win_done;
            if (valid) begin
                for (int r = 0; r < `CNN_KER; r++) begin
                    for (int k = 0; k < `CNN_KER - 1; k++) begin
                        window.px[r][k] <= window.px[r][k+1];
                    end
                    window.px[r][`CNN_KER-1] <= new_col[r];
                end

                if (col_last) begin
                    col_cnt <= '0;
                    if (row_last) begin
                        row_cnt <= '0;
                    end else begin
                        row_cnt <= row_cnt + 1'b1;
                    end
                end else begin
                    col_cnt <= col_cnt + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* design/dw_conv.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cnn_macros.svh"

module dw_conv (
    input  wire logic                clk,
    input  wire logic                rstn,
    input  wire logic                valid,
    input  wire cnn_pkg::window_t    window,
    output logic                     dw_valid,
    output cnn_pkg::in_pixel_t       dw_act
);

    import cnn_pkg::*;

    // Nine taps of up to -2 * 255 need 14 signed bits
    localparam int SUM_W   = `CNN_ACT_W + 6;
    localparam int ACT_MAX = (1 << `CNN_ACT_W) - 1;

    logic signed [SUM_W-1:0] acc     [`CNN_IN_CH];
    logic signed [SUM_W-1:0] shifted [`CNN_IN_CH];
    in_pixel_t               dw_next;

    always_comb begin
        for (int c = 0; c < `CNN_IN_CH; c++) begin
            acc[c] = '0;
            for (int i = 0; i < `CNN_KER; i++) begin
                for (int j = 0; j < `CNN_KER; j++) begin
                    acc[c] = acc[c] + $signed({1'b0, window.px[i][j].ch[c]}) * DW_WEIGHTS[c][i][j];
                end
            end
        end
    end

    // ReLU, requantize, then clip to the activation range
    always_comb begin
        for (int c = 0; c < `CNN_IN_CH; c++) begin
            if (acc[c] < 0) begin
                shifted[c] = '0;
            end else begin
                shifted[c] = acc[c] >>> `CNN_DW_SHIFT;
            end

            if (shifted[c] > ACT_MAX) begin
                dw_next.ch[c] = '1;
            end else begin
                dw_next.ch[c] = shifted[c][`CNN_ACT_W-1:0];
            end
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            dw_valid <= 1'b0;
            dw_act   <= '0;
        end else begin
            dw_valid <= valid;
            if (valid) begin
                dw_act <= dw_next;
            end
        end
    end

endmodule

`default_nettype wire

/* design/pw_conv.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cnn_macros.svh"

module pw_conv (
    input  wire logic                clk,
    input  wire logic                rstn,
    input  wire logic                valid,
    input  wire cnn_pkg::in_pixel_t  act,
    output logic                     pw_valid,
    output cnn_pkg::out_pixel_t      pw_act
);

    import cnn_pkg::*;

    localparam int SUM_W = `CNN_ACT_W + 3;

    logic signed [SUM_W-1:0] acc     [`CNN_OUT_CH];
    logic signed [SUM_W-1:0] shifted [`CNN_OUT_CH];
    out_pixel_t              pw_next;

    // No weight row has two positive taps, so the shifted sum stays below 256
    always_comb begin
        for (int o = 0; o < `CNN_OUT_CH; o++) begin
            acc[o] = '0;
            for (int c = 0; c < `CNN_IN_CH; c++) begin
                acc[o] = acc[o] + $signed({1'b0, act.ch[c]}) * PW_WEIGHTS[o][c];
            end

            if (acc[o] < 0) begin
                shifted[o] = '0;
            end else begin
                shifted[o] = acc[o] >>> `CNN_PW_SHIFT;
            end
            pw_next.ch[o] = shifted[o][`CNN_ACT_W-1:0];
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pw_valid <= 1'b0;
            pw_act   <= '0;
        end else begin
            pw_valid <= valid;
            if (valid) begin
                pw_act <= pw_next;
            end
        end
    end

endmodule

`default_nettype wire

/* design/global_avg_pool.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cnn_macros.svh"

module global_avg_pool (
    input  wire logic                clk,
    input  wire logic                rstn,
    input  wire logic                valid,
    input  wire cnn_pkg::out_pixel_t act,
    output logic                     pool_valid,
    output cnn_pkg::out_pixel_t      pool_act
);

    import cnn_pkg::*;

    // 64 values of at most 255 fit in 14 bits
    localparam int ACC_W = `CNN_ACT_W + `CNN_POOL_SHIFT;

    logic [ACC_W-1:0]           acc      [`CNN_OUT_CH];
    logic [ACC_W-1:0]           sum_next [`CNN_OUT_CH];
    logic [`CNN_POOL_SHIFT-1:0] count;
    logic                       last;

    assign last = (count == '1);

    always_comb begin
        for (int o = 0; o < `CNN_OUT_CH; o++) begin
            sum_next[o] = acc[o] + ACC_W'(act.ch[o]);
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            count      <= '0;
            pool_valid <= 1'b0;
            pool_act   <= '0;
            for (int o = 0; o < `CNN_OUT_CH; o++) begin
                acc[o] <= '0;
            end
        end else begin
            pool_valid <= valid && last;
            if (valid) begin
                count <= count + 1'b1;
                for (int o = 0; o < `CNN_OUT_CH; o++) begin
                    if (last) begin
                        // Division by the position count is a plain shift
                        pool_act.ch[o] <= sum_next[o][`CNN_POOL_SHIFT +: `CNN_ACT_W];
                        acc[o]         <= '0;
                    end else begin
                        acc[o] <= sum_next[o];
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

/* design/cnn_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cnn_top (
    input  wire logic                clk,
    input  wire logic                rstn,
    input  wire logic                valid,
    input  wire cnn_pkg::in_pixel_t  input_act,
    output cnn_pkg::out_pixel_t      output_act,
    output logic                     ready
);

    import cnn_pkg::*;

    logic       valid_ff;
    in_pixel_t  input_act_ff;

    logic       win_valid;
    window_t    window;
    logic       dw_valid;
    in_pixel_t  dw_act;
    logic       pw_valid;
    out_pixel_t pw_act;
    logic       pool_valid;
    out_pixel_t pool_act;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid_ff     <= 1'b0;
            input_act_ff <= '0;
        end else begin
            valid_ff     <= valid;
            input_act_ff <= input_act;
        end
    end

    window_buffer window_buffer_inst (
        .clk       (clk),
        .rstn      (rstn),
        .valid     (valid_ff),
        .pixel     (input_act_ff),
        .win_valid (win_valid),
        .window    (window)
    );

    dw_conv dw_conv_inst (
        .clk      (clk),
        .rstn     (rstn),
        .valid    (win_valid),
        .window   (window),
        .dw_valid (dw_valid),
        .dw_act   (dw_act)
    );

    pw_conv pw_conv_inst (
        .clk      (clk),
        .rstn     (rstn),
        .valid    (dw_valid),
        .act      (dw_act),
        .pw_valid (pw_valid),
        .pw_act   (pw_act)
    );

    global_avg_pool global_avg_pool_inst (
        .clk        (clk),
        .rstn       (rstn),
        .valid      (pw_valid),
        .act        (pw_act),
        .pool_valid (pool_valid),
        .pool_act   (pool_act)
    );

    // The result stays on output_act until the next frame completes
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            output_act <= '0;
            ready      <= 1'b0;
        end else begin
            output_act <= pool_act;
            ready      <= pool_valid;
        end
    end

endmodule

`default_nettype wire

/* tb/tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rstn
);

    localparam int PERIOD_NS = 4;

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Reset is released on a falling edge, clear of the DUT's sampling edge
    initial begin
        rstn = 1'b0;
        #(2 * PERIOD_NS) rstn = 1'b1;
    end

endmodule

`default_nettype wire

/* tb/tb_cnn_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cnn_macros.svh"

module tb_cnn_top;

    import cnn_pkg::*;

    localparam int FRAME_PIXELS = `CNN_IMG_W * `CNN_IMG_H;
    localparam int NUM_FRAMES   = 6;
    localparam int MAX_GAP      = 3;
    localparam int LATENCY      = 6;
    // Every frame at the widest pixel spacing, plus slack for reset and drain
    localparam int TIMEOUT_CYCLES = NUM_FRAMES * FRAME_PIXELS * (MAX_GAP + 1) + 1600;

    logic       clk;
    logic       rstn;
    logic       valid;
    in_pixel_t  input_act;
    out_pixel_t output_act;
    logic       ready;

    integer     seed;
    int         cycle;
    in_pixel_t  frame_px [FRAME_PIXELS];
    out_pixel_t exp_result_q [$];
    int         exp_cycle_q [$];

    tb_clock_gen tb_clock_gen_inst (
        .clk  (clk),
        .rstn (rstn)
    );

    cnn_top cnn_top_inst (
        .clk        (clk),
        .rstn       (rstn),
        .valid      (valid),
        .input_act  (input_act),
        .output_act (output_act),
        .ready      (ready)
    );

    task automatic abort_run();
        $display("Test failed");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %0d ns: %s = %0h, expected %0h", $time, name, got, exp);
            abort_run();
        end
    endtask

    function automatic int dw_weight(input int c, input int i, input int j);
        return ((3 * i + j + c) % 4) - 2;
    endfunction

    function automatic int pw_weight(input int o, input int c);
        return ((o + 2 * c) % 4) - 2;
    endfunction

    // Reference result of the whole chain for the pixels in frame_px
    function automatic out_pixel_t model_frame();
        int         dw [`CNN_IN_CH];
        int         sums [`CNN_OUT_CH];
        int         s;
        int         a;
        out_pixel_t res;
        for (int o = 0; o < `CNN_OUT_CH; o++) begin
            sums[o] = 0;
        end
        for (int r = `CNN_KER - 1; r < `CNN_IMG_H; r++) begin
            for (int col = `CNN_KER - 1; col < `CNN_IMG_W; col++) begin
                for (int c = 0; c < `CNN_IN_CH; c++) begin
                    s = 0;
                    for (int i = 0; i < `CNN_KER; i++) begin
                        for (int j = 0; j < `CNN_KER; j++) begin
                            a = frame_px[(r - 2 + i) * `CNN_IMG_W + col - 2 + j].ch[c];
                            s += a * dw_weight(c, i, j);
                        end
                    end
                    if (s < 0) s = 0;
                    s = s >> `CNN_DW_SHIFT;
                    if (s > 255) s = 255;
                    dw[c] = s;
                end
                for (int o = 0; o < `CNN_OUT_CH; o++) begin
                    s = 0;
                    for (int c = 0; c < `CNN_IN_CH; c++) begin
                        s += dw[c] * pw_weight(o, c);
                    end
                    if (s < 0) s = 0;
                    sums[o] += s >> `CNN_PW_SHIFT;
                end
            end
        end
        for (int o = 0; o < `CNN_OUT_CH; o++) begin
            res.ch[o] = 8'(sums[o] >> `CNN_POOL_SHIFT);
        end
        return res;
    endfunction

    // Mode 0 is all zero, 1 is random, 2 is full scale
    task automatic fill_frame(input int mode);
        for (int p = 0; p < FRAME_PIXELS; p++) begin
            for (int c = 0; c < `CNN_IN_CH; c++) begin
                case (mode)
                    0:       frame_px[p].ch[c] = 8'h00;
                    1:       frame_px[p].ch[c] = 8'($random(seed));
                    default: frame_px[p].ch[c] = 8'hff;
                endcase
            end
        end
    endtask

    task automatic drive_frame(input bit with_gaps);
        out_pixel_t res;
        int         gap;
        res = model_frame();
        for (int p = 0; p < FRAME_PIXELS; p++) begin
            gap = with_gaps ? ($random(seed) & MAX_GAP) : 0;
            repeat (gap) begin
                @(negedge clk);
                valid = 1'b0;
            end
            @(negedge clk);
            valid     = 1'b1;
            input_act = frame_px[p];
            if (p == FRAME_PIXELS - 1) begin
                exp_result_q.push_back(res);
                exp_cycle_q.push_back(cycle + LATENCY);
            end
        end
    endtask

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles: the output for a sent frame never arrived",
                     cycle);
            abort_run();
        end
    end

    // Each ready pulse must match the oldest pending frame, in value and in cycle
    always @(negedge clk) begin
        if (rstn && ready) begin
            if (exp_cycle_q.size() == 0) begin
                $display("Unexpected ready pulse at %0d ns with no frame pending", $time);
                abort_run();
            end else begin
                check_value("ready cycle", cycle, exp_cycle_q.pop_front());
                check_value("output_act", output_act, exp_result_q.pop_front());
            end
        end
    end

    initial begin
        valid     = 1'b0;
        input_act = '0;
        seed      = 32'hdd25;
        cycle     = 0;

        wait (rstn === 1'b1);
        repeat (4) begin
            @(negedge clk);
            check_value("ready", ready, 0);
            check_value("output_act", output_act, 0);
        end

        fill_frame(0);
        drive_frame(1'b0);
        repeat (3) begin
            fill_frame(1);
            drive_frame(1'b0);
        end
        fill_frame(1);
        drive_frame(1'b1);
        fill_frame(2);
        drive_frame(1'b0);

        @(negedge clk);
        valid     = 1'b0;
        input_act = '0;

        while (exp_cycle_q.size() != 0) begin
            @(negedge clk);
        end
        // Extra cycles so that a stray late pulse is still caught
        repeat (10) @(negedge clk);

        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
+incdir+design
design/cnn_pkg.sv
design/window_buffer.sv
design/dw_conv.sv
design/pw_conv.sv
design/global_avg_pool.sv
design/cnn_top.sv
tb/tb_clock_gen.sv
tb/tb_cnn_top.sv
